//--- ex_core.f
src/ex_pkg.sv
src/ex_alu.sv
src/ex_mult.sv
src/ex_stage.sv
src/ex_lsu.sv
src/ex_regfile.sv
src/ex_top.sv
test/ex_checker.sv
test/ex_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the execute subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module ex_tb -f ex_core.f

out=$(./obj_dir/Vex_tb)
echo "$out"

if grep -qxF '** PASS **' <<< "$out"; then
  exit 0
else
  exit 1
fi

//--- src/ex_alu.sv
////////////////////////////////////////////////////////////
// Execute ALU
// Add, sub, logic, shifts, signed set-less-than and the
// equality flag for the branch decision
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ex_alu
  import ex_pkg::*;
(
  input  ex_op_e          op_i,
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_equal_o
);

  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    sum;
  logic [XLEN-1:0]    diff;
  logic               less_signed;

  // Shift amount from the low bits of B only
  assign shamt = b_i[SHAMT_W-1:0];

  assign sum  = a_i + b_i;
  assign diff = a_i - b_i;

  // Signed compare for SLT
  assign less_signed = $signed(a_i) < $signed(b_i);

  // Branch decision input
  assign cmp_equal_o = (a_i == b_i);

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (op_i)
      OP_ADD:
        result_o = sum;
      OP_SUB:
        result_o = diff;
      OP_AND:
        result_o = a_i & b_i;
      OP_OR:
        result_o = a_i | b_i;
      OP_XOR:
        result_o = a_i ^ b_i;
      OP_SLL:
        result_o = a_i << shamt;
      OP_SRL:
        result_o = a_i >> shamt;
      OP_SLT:
        result_o = {{(XLEN-1){1'b0}}, less_signed};
      // MUL, memory and branch ops never take this result
      default:
        result_o = sum;
    endcase
  end

endmodule

`default_nettype wire

//--- src/ex_lsu.sv
////////////////////////////////////////////////////////////
// Load/store unit
// Word address adder, 16-word data memory, load return
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ex_lsu
  import ex_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_i,
  input  ex_instr_t             instr_i,
  input  logic [XLEN-1:0]       base_i,
  input  logic [XLEN-1:0]       wdata_i,
  output rf_write_t             ld_wr_o,
  output logic                  ld_pending_o,
  output logic [REG_ADDR_W-1:0] ld_rd_o
);

  logic [XLEN-1:0]        mem_q [DMEM_WORDS];
  logic [XLEN-1:0]        addr_sum;
  logic [DMEM_ADDR_W-1:0] word_addr;
  logic                   do_load;
  logic                   do_store;

  logic                  ld_valid_q;
  logic [REG_ADDR_W-1:0] ld_rd_q;
  logic [XLEN-1:0]       ld_data_q;

  // Byte address, then word index
  // Upper bits dropped so the memory aliases every 64 bytes
  assign addr_sum  = base_i + {{(XLEN-IMM_W){instr_i.imm[IMM_W-1]}}, instr_i.imm};
  assign word_addr = addr_sum[DMEM_ADDR_W+1:2];

  assign do_load  = req_i && (instr_i.op == OP_LOAD);
  assign do_store = req_i && (instr_i.op == OP_STORE);

  ////////////////////////////////////////////////////////////
  // Memory and return valid
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < DMEM_WORDS; i++)
      begin
        mem_q[i] <= '0;
      end
      ld_valid_q <= 1'b0;
    end
    else
    begin
      if (do_store)
      begin
        mem_q[word_addr] <= wdata_i;
      end
      ld_valid_q <= do_load;
    end
  end

  // Return data, presented for exactly one cycle
  always_ff @(posedge clk)
  begin
    if (do_load)
    begin
      ld_rd_q   <= instr_i.rd;
      ld_data_q <= mem_q[word_addr];
    end
  end

  assign ld_wr_o      = '{we: ld_valid_q, waddr: ld_rd_q, wdata: ld_data_q};
  assign ld_pending_o = ld_valid_q;
  assign ld_rd_o      = ld_rd_q;

endmodule

`default_nettype wire

//--- src/ex_mult.sv
////////////////////////////////////////////////////////////
// Multi-cycle multiplier, low 32 bits of a 32x32 product
// One 11-bit slice of B per cycle, accumulated over
// MULT_CYCLES cycles
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ex_mult
  import ex_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  output logic [XLEN-1:0] result_o,
  output logic            ready_o
);

  logic                  busy_q;
  logic [MULT_CNT_W-1:0] cnt_q;
  logic [XLEN-1:0]       a_q;
  logic [XLEN-1:0]       b_q;
  logic [XLEN-1:0]       acc_q;

  logic                  last;
  logic [MULT_CNT_W-1:0] idx;
  logic [XLEN-1:0]       op_a;
  logic [XLEN-1:0]       b_shifted;
  logic [XLEN-1:0]       slice;
  logic [XLEN-1:0]       partial;

  assign last = busy_q && (cnt_q == MULT_CNT_W'(MULT_CYCLES - 1));

  // Slice 0 straight from the inputs in the start cycle
  assign idx       = start_i ? '0 : cnt_q;
  assign op_a      = start_i ? a_i : a_q;
  assign b_shifted = (start_i ? b_i : b_q) >> (MULT_SLICE_W * idx);
  assign slice     = XLEN'(b_shifted[MULT_SLICE_W-1:0]);

  // Partial product, weighted by slice position
  assign partial = (op_a * slice) << (MULT_SLICE_W * idx);

  // Complete only in the last busy cycle
  assign result_o = acc_q + partial;

  // Low from the cycle after start, back high in the last count
  assign ready_o = !busy_q || last;

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end
    else if (start_i)
    begin
      busy_q <= 1'b1;
      cnt_q  <= MULT_CNT_W'(1);
    end
    else if (last)
    begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end
    else if (busy_q)
    begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Operands and running sum
  always_ff @(posedge clk)
  begin
    if (start_i)
    begin
      a_q   <= a_i;
      b_q   <= b_i;
      acc_q <= partial;
    end
    else if (busy_q)
    begin
      acc_q <= acc_q + partial;
    end
  end

endmodule

`default_nettype wire

//--- src/ex_pkg.sv
////////////////////////////////////////////////////////////
// Execute subsystem shared definitions
// Opcodes, instruction and register write structs, sizing
////////////////////////////////////////////////////////////

`default_nettype none

package ex_pkg;

  // Datapath and register file sizing
  localparam int XLEN        = 32;
  localparam int REG_ADDR_W  = 5;
  localparam int IMM_W       = 12;
  localparam int SHAMT_W     = 5;

  // Data memory, word addressed
  localparam int DMEM_WORDS  = 16;
  localparam int DMEM_ADDR_W = 4;

  // Multiplier latency and slicing
  localparam int MULT_CYCLES  = 3;
  localparam int MULT_SLICE_W = 11;
  localparam int MULT_CNT_W   = 2;

  // Opcodes
  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_OR    = 4'd3,
    OP_XOR   = 4'd4,
    OP_SLL   = 4'd5,
    OP_SRL   = 4'd6,
    OP_SLT   = 4'd7,
    OP_MUL   = 4'd8,
    OP_LOAD  = 4'd9,
    OP_STORE = 4'd10,
    OP_BEQ   = 4'd11,
    OP_BNE   = 4'd12
  } ex_op_e;

  // Instruction word, 31 bits
  // rs2 == 0 selects the sign-extended imm as operand B
  typedef struct packed {
    ex_op_e                  op;
    logic [REG_ADDR_W-1:0]   rd;
    logic [REG_ADDR_W-1:0]   rs1;
    logic [REG_ADDR_W-1:0]   rs2;
    logic signed [IMM_W-1:0] imm;
  } ex_instr_t;

  // Register write request, also the commit port
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } rf_write_t;

endpackage

`default_nettype wire

//--- src/ex_regfile.sv
////////////////////////////////////////////////////////////
// Register file, 32 x 32, x0 tied to zero
// Load-first write port arbiter, write-through reads
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ex_regfile
  import ex_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [REG_ADDR_W-1:0] raddr1_i,
  input  logic [REG_ADDR_W-1:0] raddr2_i,
  input  rf_write_t             ex_wr_i,
  input  rf_write_t             ld_wr_i,
  output logic [XLEN-1:0]       rdata1_o,
  output logic [XLEN-1:0]       rdata2_o,
  output logic                  ex_grant_o,
  output rf_write_t             commit_o
);

  localparam int NUM_REGS = 2 ** REG_ADDR_W;

  logic [XLEN-1:0] regs_q [NUM_REGS];
  rf_write_t       wr;

  // Load always wins, EX result waits a cycle
  assign wr         = ld_wr_i.we ? ld_wr_i : ex_wr_i;
  assign ex_grant_o = !ex_wr_i.we || !ld_wr_i.we;
  assign commit_o   = wr;

  // One read port, x0 first, then the write in flight
  function automatic logic [XLEN-1:0] read_port(
    input logic [REG_ADDR_W-1:0] raddr,
    input rf_write_t             w,
    input logic [XLEN-1:0]       stored
  );
    if (raddr == '0)
    begin
      return '0;
    end
    if (w.we && (w.waddr == raddr))
    begin
      return w.wdata;
    end
    return stored;
  endfunction

  assign rdata1_o = read_port(raddr1_i, wr, regs_q[raddr1_i]);
  assign rdata2_o = read_port(raddr2_i, wr, regs_q[raddr2_i]);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        regs_q[i] <= '0;
      end
    end
    // Writes to x0 are committed but dropped here
    else if (wr.we && (wr.waddr != '0))
    begin
      regs_q[wr.waddr] <= wr.wdata;
    end
  end

endmodule

`default_nettype wire

//--- src/ex_stage.sv
////////////////////////////////////////////////////////////
// Execute stage
// Operand interlock, ALU and multiplier, EX/WB register,
// LSU request and branch decision
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ex_stage
  import ex_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid_i,
  input  ex_instr_t             instr_i,
  input  logic [XLEN-1:0]       rdata1_i,
  input  logic [XLEN-1:0]       rdata2_i,
  input  logic                  ex_grant_i,
  input  logic                  ld_pending_i,
  input  logic [REG_ADDR_W-1:0] ld_rd_i,
  output logic [REG_ADDR_W-1:0] rs1_o,
  output logic [REG_ADDR_W-1:0] rs2_o,
  output rf_write_t             ex_wr_o,
  output logic                  lsu_req_o,
  output ex_instr_t             lsu_instr_o,
  output logic [XLEN-1:0]       lsu_base_o,
  output logic [XLEN-1:0]       lsu_wdata_o,
  output logic                  branch_valid_o,
  output logic                  branch_taken_o,
  output logic                  ex_ready_o
);

  // Decode
  logic is_load;
  logic is_mem;
  logic is_branch;
  logic is_mul;
  logic is_alu;
  logic accept;

  logic [XLEN-1:0] imm_ext;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_result;
  logic            alu_equal;
  logic [XLEN-1:0] mult_result;
  logic            mult_ready;
  logic            mul_done;

  // Interlock
  logic                          ex_hold;
  logic                          lsu_ld_q;
  logic [1:0][REG_ADDR_W-1:0]    src_addr;
  logic [1:0]                    src_hit;

  // State
  logic                  ex_we_q;
  logic [REG_ADDR_W-1:0] ex_waddr_q;
  logic [XLEN-1:0]       ex_wdata_q;
  logic                  mul_pend_q;
  logic [REG_ADDR_W-1:0] mul_rd_q;
  logic                  lsu_req_q;
  ex_instr_t             lsu_instr_q;
  logic [XLEN-1:0]       lsu_base_q;
  logic [XLEN-1:0]       lsu_wdata_q;
  logic                  branch_valid_q;
  logic                  branch_taken_q;

  assign rs1_o = instr_i.rs1;
  assign rs2_o = instr_i.rs2;

  assign is_load   = (instr_i.op == OP_LOAD);
  assign is_mem    = is_load || (instr_i.op == OP_STORE);
  assign is_branch = (instr_i.op == OP_BEQ) || (instr_i.op == OP_BNE);
  assign is_mul    = (instr_i.op == OP_MUL);
  assign is_alu    = !(is_mem || is_branch || is_mul);

  // Operand B: register, or imm when rs2 is x0
  assign imm_ext = {{(XLEN-IMM_W){instr_i.imm[IMM_W-1]}}, instr_i.imm};
  assign op_b    = (instr_i.rs2 == '0) ? imm_ext : rdata2_i;

  ex_alu u_alu (
    .op_i        (instr_i.op),
    .a_i         (rdata1_i),
    .b_i         (op_b),
    .result_o    (alu_result),
    .cmp_equal_o (alu_equal)
  );

  ex_mult u_mult (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (accept && is_mul),
    .a_i      (rdata1_i),
    .b_i      (op_b),
    .result_o (mult_result),
    .ready_o  (mult_ready)
  );

  // Multiplier result lands in EX/WB in its last busy cycle
  assign mul_done = mul_pend_q && mult_ready;

  ////////////////////////////////////////////////////////////
  // Interlock and handshake
  ////////////////////////////////////////////////////////////

  // Result lost the write port to a load this cycle
  assign ex_hold  = ex_we_q && !ex_grant_i;
  assign lsu_ld_q = lsu_req_q && (lsu_instr_q.op == OP_LOAD);
  assign src_addr = {instr_i.rs2, instr_i.rs1};

  always_comb
  begin
    for (int i = 0; i < 2; i++)
    begin
      src_hit[i] = (src_addr[i] != '0) &&
                   ((ex_hold && (src_addr[i] == ex_waddr_q)) ||
                    (lsu_ld_q && (src_addr[i] == lsu_instr_q.rd)) ||
                    (ld_pending_i && (src_addr[i] == ld_rd_i)));
    end
  end

  assign ex_ready_o = mult_ready && !mul_pend_q && !ex_hold && !(|src_hit);
  assign accept     = instr_valid_i && ex_ready_o;

  ////////////////////////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ex_we_q        <= 1'b0;
      mul_pend_q     <= 1'b0;
      lsu_req_q      <= 1'b0;
      branch_valid_q <= 1'b0;
    end
    else
    begin
      // EX/WB valid, held until the port is granted
      if ((accept && is_alu) || mul_done)
      begin
        ex_we_q <= 1'b1;
      end
      else if (ex_grant_i)
      begin
        ex_we_q <= 1'b0;
      end
      if (accept && is_mul)
      begin
        mul_pend_q <= 1'b1;
      end
      else if (mul_done)
      begin
        mul_pend_q <= 1'b0;
      end
      lsu_req_q      <= accept && is_mem;
      branch_valid_q <= accept && is_branch;
    end
  end

  // Payload, only meaningful with its valid bit
  always_ff @(posedge clk)
  begin
    if (accept && is_alu)
    begin
      ex_waddr_q <= instr_i.rd;
      ex_wdata_q <= alu_result;
    end
    else if (mul_done)
    begin
      ex_waddr_q <= mul_rd_q;
      ex_wdata_q <= mult_result;
    end
    if (accept && is_mul)
    begin
      mul_rd_q <= instr_i.rd;
    end
    if (accept && is_mem)
    begin
      lsu_instr_q <= instr_i;
      lsu_base_q  <= rdata1_i;
      lsu_wdata_q <= rdata2_i;
    end
    // BEQ takes on equal, BNE on not equal
    if (accept && is_branch)
    begin
      branch_taken_q <= (instr_i.op == OP_BEQ) ? alu_equal : !alu_equal;
    end
  end

  assign ex_wr_o = '{we: ex_we_q, waddr: ex_waddr_q, wdata: ex_wdata_q};

  // LSU request, one cycle after acceptance
  assign lsu_req_o   = lsu_req_q;
  assign lsu_instr_o = lsu_instr_q;
  assign lsu_base_o  = lsu_base_q;
  assign lsu_wdata_o = lsu_wdata_q;

  // Branch outcome, one cycle after acceptance
  assign branch_valid_o = branch_valid_q;
  assign branch_taken_o = branch_taken_q;

endmodule

`default_nettype wire

//--- src/ex_top.sv
////////////////////////////////////////////////////////////
// Execute subsystem top
// Stage, LSU and register file around one write port
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ex_top
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      instr_valid_i,
  input  ex_instr_t instr_i,
  output logic      ex_ready_o,
  output rf_write_t commit_o,
  output logic      branch_valid_o,
  output logic      branch_taken_o
);

  // Register file read side
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [XLEN-1:0]       rdata1;
  logic [XLEN-1:0]       rdata2;

  // Write port requests
  rf_write_t ex_wr;
  rf_write_t ld_wr;
  logic      ex_grant;

  // Stage to LSU
  logic                  lsu_req;
  ex_instr_t             lsu_instr;
  logic [XLEN-1:0]       lsu_base;
  logic [XLEN-1:0]       lsu_wdata;
  logic                  ld_pending;
  logic [REG_ADDR_W-1:0] ld_rd;

  ex_stage u_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .rdata1_i       (rdata1),
    .rdata2_i       (rdata2),
    .ex_grant_i     (ex_grant),
    .ld_pending_i   (ld_pending),
    .ld_rd_i        (ld_rd),
    .rs1_o          (rs1),
    .rs2_o          (rs2),
    .ex_wr_o        (ex_wr),
    .lsu_req_o      (lsu_req),
    .lsu_instr_o    (lsu_instr),
    .lsu_base_o     (lsu_base),
    .lsu_wdata_o    (lsu_wdata),
    .branch_valid_o (branch_valid_o),
    .branch_taken_o (branch_taken_o),
    .ex_ready_o     (ex_ready_o)
  );

  ex_lsu u_lsu (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (lsu_req),
    .instr_i      (lsu_instr),
    .base_i       (lsu_base),
    .wdata_i      (lsu_wdata),
    .ld_wr_o      (ld_wr),
    .ld_pending_o (ld_pending),
    .ld_rd_o      (ld_rd)
  );

  ex_regfile u_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .raddr1_i   (rs1),
    .raddr2_i   (rs2),
    .ex_wr_i    (ex_wr),
    .ld_wr_i    (ld_wr),
    .rdata1_o   (rdata1),
    .rdata2_o   (rdata2),
    .ex_grant_o (ex_grant),
    .commit_o   (commit_o)
  );

endmodule

`default_nettype wire

//--- test/ex_checker.sv
////////////////////////////////////////////////////////////
// Execute subsystem checker
// Reference model of registers and memory, compares
// commits, branch outcomes and multiplier stalls
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ex_checker
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      instr_valid_i,
  input  ex_instr_t instr_i,
  input  logic      ex_ready_i,
  input  rf_write_t commit_i,
  input  logic      branch_valid_i,
  input  logic      branch_taken_i,
  input  logic      end_i,
  output int        pending_o,
  output int        errors_o,
  output logic      done_o
);

  // Reference state
  logic [XLEN-1:0] model_regs [2**REG_ADDR_W];
  logic [XLEN-1:0] model_mem  [DMEM_WORDS];

  // Expected results in program order
  rf_write_t exp_q   [$];
  int        due_q   [$];
  logic      taken_q [$];

  int cycle;
  int mul_stall;
  int n_commits;
  int value_errs;
  int timing_errs;
  int seq_errs;

  ////////////////////////////////////////////////////////////
  // Reference model, one instruction at a time
  ////////////////////////////////////////////////////////////

  function automatic void apply_instr(
    input  ex_instr_t ins,
    output rf_write_t wr,
    output logic      is_branch,
    output logic      taken
  );
    logic [XLEN-1:0]        a;
    logic [XLEN-1:0]        b;
    logic [XLEN-1:0]        imm_ext;
    logic [XLEN-1:0]        res;
    logic [XLEN-1:0]        addr;
    logic [DMEM_ADDR_W-1:0] word;
    imm_ext   = {{(XLEN-IMM_W){ins.imm[IMM_W-1]}}, ins.imm};
    a         = (ins.rs1 == '0) ? '0 : model_regs[ins.rs1];
    // rs2 of x0 means the immediate
    b         = (ins.rs2 == '0) ? imm_ext : model_regs[ins.rs2];
    addr      = a + imm_ext;
    // 16 words, aliasing every 64 bytes
    word      = addr[DMEM_ADDR_W+1:2];
    res       = '0;
    wr        = '0;
    is_branch = 1'b0;
    taken     = 1'b0;
    case (ins.op)
      OP_ADD:   res = a + b;
      OP_SUB:   res = a - b;
      OP_AND:   res = a & b;
      OP_OR:    res = a | b;
      OP_XOR:   res = a ^ b;
      OP_SLL:   res = a << b[4:0];
      OP_SRL:   res = a >> b[4:0];
      OP_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_MUL:   res = a * b;
      OP_LOAD:  res = model_mem[word];
      // Store data is the register, never the immediate
      OP_STORE: model_mem[word] = (ins.rs2 == '0) ? '0 : model_regs[ins.rs2];
      OP_BEQ:
      begin
        is_branch = 1'b1;
        taken     = (a == b);
      end
      OP_BNE:
      begin
        is_branch = 1'b1;
        taken     = (a != b);
      end
      default: ;
    endcase
    if (!is_branch && ins.op != OP_STORE)
    begin
      wr = '{we: 1'b1, waddr: ins.rd, wdata: res};
      // x0 commits, but keeps reading zero
      if (ins.rd != '0)
      begin
        model_regs[ins.rd] = res;
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare at every rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    rf_write_t exp_wr;
    int        due;
    logic      exp_taken;
    logic      is_br;
    logic      br_taken;
    if (!rst_n)
    begin
      for (int i = 0; i < 2**REG_ADDR_W; i++)
      begin
        model_regs[i] = '0;
      end
      for (int i = 0; i < DMEM_WORDS; i++)
      begin
        model_mem[i] = '0;
      end
      exp_q.delete();
      due_q.delete();
      taken_q.delete();
      cycle       = 0;
      mul_stall   = 0;
      n_commits   = 0;
      value_errs  = 0;
      timing_errs = 0;
      seq_errs    = 0;
      pending_o <= 0;
      errors_o  <= 0;
      done_o    <= 1'b0;
    end
    else
    begin
      // Commit port against the oldest expected result
      if (commit_i.we)
      begin
        n_commits++;
        if (exp_q.size() == 0)
        begin
          $display("unexpected commit to x%0d at %0t while no result was outstanding",
                   commit_i.waddr, $time);
          seq_errs++;
        end
        else
        begin
          exp_wr = exp_q.pop_front();
          due    = due_q.pop_front();
          if (commit_i.waddr !== exp_wr.waddr)
          begin
            $display("error at %0t: commit_o.waddr expected %0d got %0d",
                     $time, exp_wr.waddr, commit_i.waddr);
            value_errs++;
          end
          if (commit_i.wdata !== exp_wr.wdata)
          begin
            $display("error at %0t: commit_o.wdata expected %h got %h",
                     $time, exp_wr.wdata, commit_i.wdata);
            value_errs++;
          end
          // Loads and multiplies have a fixed latency
          if (due >= 0 && cycle != due)
          begin
            $display("result for x%0d committed in cycle %0d instead of cycle %0d",
                     commit_i.waddr, cycle, due);
            timing_errs++;
          end
        end
      end

      // Branch outcome
      if (branch_valid_i)
      begin
        if (taken_q.size() == 0)
        begin
          $display("unexpected branch outcome at %0t with no branch outstanding", $time);
          seq_errs++;
        end
        else
        begin
          exp_taken = taken_q.pop_front();
          if (branch_taken_i !== exp_taken)
          begin
            $display("error at %0t: branch_taken_o expected %0b got %0b",
                     $time, exp_taken, branch_taken_i);
            value_errs++;
          end
        end
      end

      // Multiplier busy window
      if (mul_stall > 0)
      begin
        if (ex_ready_i)
        begin
          $display("ex_ready_o was high at %0t while the multiplier was busy", $time);
          timing_errs++;
        end
        mul_stall--;
      end

      // New instruction enters the model
      if (instr_valid_i && ex_ready_i)
      begin
        apply_instr(instr_i, exp_wr, is_br, br_taken);
        if (exp_wr.we)
        begin
          exp_q.push_back(exp_wr);
          // Load two cycles, multiply one cycle after its busy window
          if (instr_i.op == OP_LOAD)
          begin
            due_q.push_back(cycle + 2);
          end
          else if (instr_i.op == OP_MUL)
          begin
            due_q.push_back(cycle + MULT_CYCLES);
          end
          else
          begin
            due_q.push_back(-1);
          end
        end
        if (is_br)
        begin
          taken_q.push_back(br_taken);
        end
        if (instr_i.op == OP_MUL)
        begin
          mul_stall = MULT_CYCLES - 1;
        end
      end

      cycle++;
      pending_o <= exp_q.size() + taken_q.size();

      // Closing report
      if (end_i && !done_o)
      begin
        if (exp_q.size() != 0 || taken_q.size() != 0)
        begin
          $display("%0d results and %0d branch outcomes never appeared",
                   exp_q.size(), taken_q.size());
          seq_errs++;
        end
        $display("checker: %0d commits, %0d value errors, %0d timing errors, %0d sequence errors",
                 n_commits, value_errs, timing_errs, seq_errs);
        errors_o <= value_errs + timing_errs + seq_errs;
        done_o   <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/ex_tb.sv
////////////////////////////////////////////////////////////
// Execute subsystem testbench
// Clock, reset, directed and seeded random instructions
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ex_tb
  import ex_pkg::*;
();

  localparam int NUM_SETUP      = 32;
  localparam int NUM_DIRECTED   = 10;
  localparam int NUM_RANDOM     = 400;
  localparam int CLK_HALF       = 10;
  // Worst case per instruction plus reset and drain
  localparam int TIMEOUT_CYCLES =
    (NUM_SETUP + NUM_DIRECTED + NUM_RANDOM) * (MULT_CYCLES + 3) + 100;

  logic      clk;
  logic      rst_n;
  logic      instr_valid;
  ex_instr_t instr;
  logic      ex_ready;
  rf_write_t commit;
  logic      branch_valid;
  logic      branch_taken;

  // Checker handshake
  logic end_req;
  int   pending;
  int   errors;
  logic report_done;
  int   cycle_cnt;

  ex_top DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .ex_ready_o     (ex_ready),
    .commit_o       (commit),
    .branch_valid_o (branch_valid),
    .branch_taken_o (branch_taken)
  );

  ex_checker u_checker (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .ex_ready_i     (ex_ready),
    .commit_i       (commit),
    .branch_valid_i (branch_valid),
    .branch_taken_i (branch_taken),
    .end_i          (end_req),
    .pending_o      (pending),
    .errors_o       (errors),
    .done_o         (report_done)
  );

  // 20 ns clock
  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  // Run limit
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic ex_instr_t make_instr(
    input ex_op_e op,
    input int     rd,
    input int     rs1,
    input int     rs2,
    input int     imm
  );
    ex_instr_t ins;
    ins.op  = op;
    ins.rd  = REG_ADDR_W'(rd);
    ins.rs1 = REG_ADDR_W'(rs1);
    ins.rs2 = REG_ADDR_W'(rs2);
    ins.imm = IMM_W'(imm);
    return ins;
  endfunction

  // Small register set, so dependencies are common
  function automatic ex_instr_t random_instr();
    ex_instr_t ins;
    ins.op  = ex_op_e'(4'($urandom % 13));
    ins.rd  = REG_ADDR_W'($urandom % 8);
    ins.rs1 = REG_ADDR_W'($urandom % 8);
    ins.rs2 = REG_ADDR_W'($urandom % 8);
    ins.imm = IMM_W'($urandom);
    // Base of x0 half the time, addresses collide often
    if ((ins.op == OP_LOAD || ins.op == OP_STORE) && ($urandom % 2 == 0))
    begin
      ins.rs1 = '0;
    end
    return ins;
  endfunction

  // Hold the instruction until the stage takes it
  task automatic issue(input ex_instr_t ins);
    instr_valid <= 1'b1;
    instr       <= ins;
    @(posedge clk);
    while (!ex_ready)
    begin
      @(posedge clk);
    end
    instr_valid <= 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    instr_valid <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  task automatic directed_sequence();
    // Store then aliased load of the same word
    issue(make_instr(OP_STORE, 0, 0, 5, 'h010));
    issue(make_instr(OP_LOAD, 6, 0, 0, 'h050));
    // Reads the load result through the interlock
    issue(make_instr(OP_ADD, 7, 6, 0, 1));
    // Load and ALU op fight for the write port
    issue(make_instr(OP_LOAD, 1, 0, 0, 'h010));
    issue(make_instr(OP_ADD, 2, 3, 4, 0));
    // Multiply, then a dependent subtract
    issue(make_instr(OP_MUL, 3, 6, 7, 0));
    issue(make_instr(OP_SUB, 4, 3, 6, 0));
    issue(make_instr(OP_BEQ, 0, 6, 6, 0));
    issue(make_instr(OP_BNE, 0, 6, 6, 0));
    // x0 as destination
    issue(make_instr(OP_ADD, 0, 7, 0, 'h123));
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    int gap;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    end_req     = 1'b0;
    cycle_cnt   = 0;
    void'($urandom(32'hbe6));

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Every register from an immediate
    for (int i = 0; i < NUM_SETUP; i++)
    begin
      issue(make_instr(OP_ADD, i, 0, 0, int'($urandom % 4096)));
    end

    directed_sequence();

    // Random stream with occasional idle gaps
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      issue(random_instr());
      if ($urandom % 4 == 0)
      begin
        gap = int'($urandom % 2) + 1;
        idle_cycles(gap);
      end
    end

    // Drain, then a quiet window for stray commits
    @(posedge clk);
    while (pending != 0)
    begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    end_req <= 1'b1;
    @(posedge clk);
    while (!report_done)
    begin
      @(posedge clk);
    end

    if (errors == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
